// File: verilog.f
design/alert_prot_pkg.sv
design/alert_cfg_pkg.sv
design/alert_evt_if.sv
design/alert_receiver.sv
design/class_ctrl.sv
design/esc_sender.sv
design/alert_handler.sv
test/tb_alert_handler.sv

// File: Bender.yml
package:
  name: alert_handler

sources:
  - files:
      - design/alert_prot_pkg.sv
      - design/alert_cfg_pkg.sv
      - design/alert_evt_if.sv
      - design/alert_receiver.sv
      - design/class_ctrl.sv
      - design/esc_sender.sv
      - design/alert_handler.sv
  - target: test
    files:
      - test/tb_alert_handler.sv

// File: test/tb_alert_handler.sv
// table-driven testbench for the alert handler, one alert index active per row
// esc_fail is sticky until reset, so the frozen-response row has to stay last
`timescale 1ns/1ns

module tb_alert_handler
  import alert_prot_pkg::*;
  import alert_cfg_pkg::*;
();

  typedef struct packed {
    logic [1:0]            idx;
    logic                  bad;
    logic [NumAlerts-1:0]  alert_en;
    logic [NumAlerts-1:0]  class_map;
    logic [NumClasses-1:0] class_en;
    logic [AccuW-1:0]      thresh;
    logic [CyclesW-1:0]    cycles;
    logic [3:0]            count;
    logic [NumEsc-1:0]     freeze;
    logic [NumClasses-1:0] exp_intr;
    logic [NumEsc-1:0]     exp_esc;
    logic [NumEsc-1:0]     exp_fail;
  } row_t;

  localparam int NumRows = 6;

  // idx, bad pair, alert_en, class_map, class_en, thresh, cycles, count,
  // freeze, expected intr, expected esc in terminal, expected esc_fail
  row_t rows [NumRows] = '{
    '{2'd0, 1'b0, 4'b1111, 4'b0000, 2'b11, 8'd5, 8'd2, 4'd3, 2'b00, 2'b01, 2'b00, 2'b00},
    '{2'd2, 1'b0, 4'b1111, 4'b0100, 2'b11, 8'd3, 8'd1, 4'd3, 2'b00, 2'b10, 2'b11, 2'b00},
    '{2'd1, 1'b0, 4'b1111, 4'b0010, 2'b01, 8'd1, 8'd1, 4'd2, 2'b00, 2'b00, 2'b00, 2'b00},
    '{2'd3, 1'b0, 4'b0111, 4'b0000, 2'b11, 8'd1, 8'd1, 4'd2, 2'b00, 2'b00, 2'b00, 2'b00},
    '{2'd1, 1'b1, 4'b1111, 4'b0000, 2'b11, 8'd1, 8'd0, 4'd1, 2'b00, 2'b01, 2'b11, 2'b00},
    '{2'd0, 1'b0, 4'b1111, 4'b0000, 2'b11, 8'd2, 8'd3, 4'd2, 2'b01, 2'b01, 2'b11, 2'b01}
  };

  logic                            clk_i;
  logic                            arst_n_i;
  alert_tx_t [NumAlerts-1:0]       alert_tx_i;
  alert_rx_t [NumAlerts-1:0]       alert_rx_o;
  logic      [NumAlerts-1:0]       alert_en_i;
  logic      [NumAlerts-1:0]       class_map_i;
  logic      [NumClasses-1:0]      class_en_i;
  logic      [AccuW-1:0]           accum_thresh_i;
  logic      [CyclesW-1:0]         esc_cycles_i;
  logic      [NumClasses-1:0]      clr_i;
  logic      [NumClasses-1:0]      intr_o;
  esc_tx_t   [NumEsc-1:0]          esc_tx_o;
  esc_rx_t   [NumEsc-1:0]          esc_rx_i;
  logic      [NumEsc-1:0]          esc_fail_o;
  logic      [CrashW-1:0]          crashdump_o;

  logic [NumEsc-1:0] freeze_q;
  logic [31:0]       lfsr_q;
  int                cycle_cnt;
  int                p0_len;
  logic              order_bad;

  alert_handler u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [NumEsc-1:0] esc_vec();
    logic [NumEsc-1:0] v;
    for (int e = 0; e < NumEsc; e++) begin
      v[e] = esc_tx_o[e].esc_p;
    end
    return v;
  endfunction

  // alert source, four-phase handshake or a forced equal pair
  task automatic send_alert(input int k, input logic bad);
    if (bad) begin
      alert_tx_i[k] = '{alert_p: 1'b1, alert_n: 1'b1};
      repeat (2) next_cycle();
      check_value("ack_p on bad pair", alert_rx_o[k].ack_p, 1'b0);
    end else begin
      alert_tx_i[k] = '{alert_p: 1'b1, alert_n: 1'b0};
      do next_cycle(); while (!alert_rx_o[k].ack_p);
    end
    alert_tx_i[k] = '{alert_p: 1'b0, alert_n: 1'b1};
    while (alert_rx_o[k].ack_p) begin
      next_cycle();
    end
    check_value("ack_n after release", alert_rx_o[k].ack_n, 1'b1);
  endtask

  // escalation devices, a frozen one keeps the idle pair
  initial begin
    esc_rx_i = {NumEsc{esc_rx_t'{resp_p: 1'b0, resp_n: 1'b1}}};
    forever begin
      next_cycle();
      for (int e = 0; e < NumEsc; e++) begin
        if (esc_tx_o[e].esc_p && !freeze_q[e]) begin
          esc_rx_i[e] = '{resp_p: ~esc_rx_i[e].resp_p, resp_n: esc_rx_i[e].resp_p};
        end else begin
          esc_rx_i[e] = '{resp_p: 1'b0, resp_n: 1'b1};
        end
      end
    end
  end

  // phase 0 length and pair checks, sampled mid-cycle
  always @(negedge clk_i) begin
    if (arst_n_i) begin
      for (int k = 0; k < NumAlerts; k++) begin
        check_value($sformatf("ack pair %0d", k), alert_rx_o[k].ack_p ^ alert_rx_o[k].ack_n, 1'b1);
      end
      for (int e = 0; e < NumEsc; e++) begin
        check_value($sformatf("esc pair %0d", e), esc_tx_o[e].esc_p ^ esc_tx_o[e].esc_n, 1'b1);
      end
      if (esc_tx_o[0].esc_p && !esc_tx_o[1].esc_p) begin
        p0_len = p0_len + 1;
      end
      if (esc_tx_o[1].esc_p && !esc_tx_o[0].esc_p) begin
        order_bad = 1'b1;
      end
    end
  end

  initial begin
    int limit;
    limit = 40;
    for (int r = 0; r < NumRows; r++) begin
      limit = limit + rows[r].count * 20 + 3 * (rows[r].cycles + 1) + 40;
    end
    cycle_cnt = 0;
    forever begin
      @(posedge clk_i);
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt > limit) begin
        $display("timeout: the run did not finish within %0d cycles", limit);
        $display("TB FAILED");
        $fatal(1);
      end
    end
  end

  initial begin
    row_t              row;
    int                cls;
    int                cnt_model;
    logic              dumped;
    logic [CrashW-1:0] crash_exp;
    logic [1:0]        gap;
    arst_n_i       = 1'b0;
    alert_tx_i     = {NumAlerts{alert_tx_t'{alert_p: 1'b0, alert_n: 1'b1}}};
    alert_en_i     = '0;
    class_map_i    = '0;
    class_en_i     = '0;
    accum_thresh_i = '0;
    esc_cycles_i   = '0;
    clr_i          = '0;
    freeze_q       = '0;
    lfsr_q         = 32'hb995_63a5;
    p0_len         = 0;
    order_bad      = 1'b0;
    dumped         = 1'b0;
    crash_exp      = '0;
    repeat (16) next_cycle();
    arst_n_i = 1'b1;
    next_cycle();
    check_value("intr_o after reset", intr_o, '0);
    check_value("esc vector after reset", esc_vec(), '0);
    check_value("esc_fail_o after reset", esc_fail_o, '0);
    check_value("crashdump_o after reset", crashdump_o, '0);

    for (int r = 0; r < NumRows; r++) begin
      row            = rows[r];
      cls            = row.class_map[row.idx];
      cnt_model      = 0;
      alert_en_i     = row.alert_en;
      class_map_i    = row.class_map;
      class_en_i     = row.class_en;
      accum_thresh_i = row.thresh;
      esc_cycles_i   = row.cycles;
      freeze_q       = row.freeze;
      p0_len         = 0;
      order_bad      = 1'b0;
      for (int a = 0; a < row.count; a++) begin
        send_alert(row.idx, row.bad);
        if (row.alert_en[row.idx] && row.class_en[cls]) begin
          cnt_model = cnt_model + 1;
          if (!dumped && (cnt_model >= row.thresh)) begin
            dumped = 1'b1;
            crash_exp[cls*(2+AccuW) +: (2+AccuW)] = {ESC_PHASE0, AccuW'(cnt_model)};
          end
        end
        for (int b = 0; b < 2; b++) begin
          lfsr_q = lfsr_next(lfsr_q);
          gap    = {gap[0], lfsr_q[0]};
        end
        repeat (gap) next_cycle();
      end
      if (row.exp_esc != '0) begin
        while (!esc_tx_o[1].esc_p) begin
          next_cycle();
        end
        // stay a while in terminal
        repeat (row.cycles + 4) next_cycle();
        check_value("phase 0 length", p0_len, row.cycles + 1);
      end else begin
        repeat (3 * (row.cycles + 1) + 6) next_cycle();
        check_value("phase 0 length", p0_len, 0);
      end
      check_value("esc order", order_bad, 1'b0);
      check_value("intr_o", intr_o, row.exp_intr);
      check_value("esc vector", esc_vec(), row.exp_esc);
      check_value("esc_fail_o", esc_fail_o, row.exp_fail);
      check_value("crashdump_o", crashdump_o, crash_exp);
      clr_i = '1;
      next_cycle();
      clr_i = '0;
      repeat (3) next_cycle();
      check_value("intr_o after clear", intr_o, '0);
      check_value("esc vector after clear", esc_vec(), '0);
    end
    $display("TB PASSED");
    $finish;
  end

endmodule

// File: design/alert_handler.sv
// alert handler top: 4 alert receivers, class controller, 2 escalation senders
// configuration ports must stay stable while alerts are in flight
`timescale 1ns/1ns

module alert_handler
  import alert_prot_pkg::*;
  import alert_cfg_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  alert_tx_t [NumAlerts-1:0]  alert_tx_i,
  output alert_rx_t [NumAlerts-1:0]  alert_rx_o,
  input  logic      [NumAlerts-1:0]  alert_en_i,
  input  logic      [NumAlerts-1:0]  class_map_i,
  input  logic      [NumClasses-1:0] class_en_i,
  input  logic      [AccuW-1:0]      accum_thresh_i,
  input  logic      [CyclesW-1:0]    esc_cycles_i,
  input  logic      [NumClasses-1:0] clr_i,
  output logic      [NumClasses-1:0] intr_o,
  output esc_tx_t   [NumEsc-1:0]     esc_tx_o,
  input  esc_rx_t   [NumEsc-1:0]     esc_rx_i,
  output logic      [NumEsc-1:0]     esc_fail_o,
  output logic      [CrashW-1:0]     crashdump_o
);

  logic [NumEsc-1:0] esc_req;

  alert_evt_if u_evt ();

  assign u_evt.alert_en = alert_en_i;

  for (genvar k = 0; k < NumAlerts; k++) begin : gen_rx
    assign u_evt.alert_cls[k] = class_e'(class_map_i[k]);

    alert_receiver u_alert_receiver (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .alert_tx_i   (alert_tx_i[k]),
      .alert_rx_o   (alert_rx_o[k]),
      .alert_o      (u_evt.alert_stb[k]),
      .integ_fail_o (u_evt.integ_stb[k])
    );
  end

  class_ctrl u_class_ctrl (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .evt            (u_evt),
    .class_en_i     (class_en_i),
    .accum_thresh_i (accum_thresh_i),
    .esc_cycles_i   (esc_cycles_i),
    .clr_i          (clr_i),
    .intr_o         (intr_o),
    .esc_req_o      (esc_req),
    .crashdump_o    (crashdump_o)
  );

  for (genvar e = 0; e < NumEsc; e++) begin : gen_esc
    esc_sender u_esc_sender (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .esc_req_i  (esc_req[e]),
      .esc_rx_i   (esc_rx_i[e]),
      .esc_tx_o   (esc_tx_o[e]),
      .esc_fail_o (esc_fail_o[e])
    );
  end

endmodule

// File: design/esc_sender.sv
// escalation sender with response check
// device answers one cycle after it sees esc_p, so one bad cycle
// is tolerated at each request edge; fail is sticky until reset
`timescale 1ns/1ns

module esc_sender
  import alert_prot_pkg::*;
(
  input  logic    clk_i,
  input  logic    arst_n_i,
  input  logic    esc_req_i,
  input  esc_rx_t esc_rx_i,
  output esc_tx_t esc_tx_o,
  output logic    esc_fail_o
);

  logic esc_p_q;
  logic esc_n_q;
  logic resp_p_q;
  logic resp_bad;
  logic bad_q;
  logic fail_q;

  // active: toggling complements, inactive: idle pair
  always_comb begin
    if (esc_p_q) begin
      resp_bad = (esc_rx_i.resp_p == esc_rx_i.resp_n) || (esc_rx_i.resp_p == resp_p_q);
    end else begin
      resp_bad = esc_rx_i.resp_p || !esc_rx_i.resp_n;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      esc_p_q  <= 1'b0;
      esc_n_q  <= 1'b1;
      resp_p_q <= 1'b0;
      bad_q    <= 1'b0;
      fail_q   <= 1'b0;
    end else begin
      esc_p_q  <= esc_req_i;
      esc_n_q  <= ~esc_req_i;
      resp_p_q <= esc_rx_i.resp_p;
      bad_q    <= resp_bad;
      if (resp_bad && bad_q) begin
        fail_q <= 1'b1;
      end
    end
  end

  assign esc_tx_o   = '{esc_p: esc_p_q, esc_n: esc_n_q};
  assign esc_fail_o = fail_q;

  a_esc_compl: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    esc_tx_o.esc_p != esc_tx_o.esc_n);

endmodule

// File: design/class_ctrl.sv
// per-class alert accumulation, sticky interrupts and escalation phase timers
// thresholds and phase lengths are shared by both classes; crashdump holds until reset
`timescale 1ns/1ns

module class_ctrl
  import alert_cfg_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  alert_evt_if.ctrl             evt,
  input  logic [NumClasses-1:0] class_en_i,
  input  logic [AccuW-1:0]      accum_thresh_i,
  input  logic [CyclesW-1:0]    esc_cycles_i,
  input  logic [NumClasses-1:0] clr_i,
  output logic [NumClasses-1:0] intr_o,
  output logic [NumEsc-1:0]     esc_req_o,
  output logic [CrashW-1:0]     crashdump_o
);

  logic       [NumClasses-1:0][AccuW-1:0]   inc;
  logic       [NumClasses-1:0][AccuW-1:0]   accu_q, accu_d;
  logic       [NumClasses-1:0][CyclesW-1:0] timer_q, timer_d;
  esc_state_e [NumClasses-1:0]              state_q, state_d;
  logic       [NumClasses-1:0]              intr_q, intr_d;
  logic       [NumClasses-1:0][AccuW+1:0]   crash_q;
  logic                                     dumped_q;
  logic                                     leave_idle;

  // alerts and integrity failures of this class in this cycle
  always_comb begin
    for (int c = 0; c < NumClasses; c++) begin
      inc[c] = '0;
      for (int k = 0; k < NumAlerts; k++) begin
        if (class_en_i[c] && evt.alert_en[k] && (evt.alert_cls[k] == class_e'(c))) begin
          inc[c] = inc[c] + AccuW'(evt.alert_stb[k]) + AccuW'(evt.integ_stb[k]);
        end
      end
    end
  end

  always_comb begin
    logic [AccuW:0] sum;
    accu_d  = accu_q;
    intr_d  = intr_q;
    state_d = state_q;
    timer_d = timer_q;
    for (int c = 0; c < NumClasses; c++) begin
      sum       = {1'b0, accu_q[c]} + {1'b0, inc[c]};
      accu_d[c] = sum[AccuW] ? '1 : sum[AccuW-1:0];
      if (inc[c] != '0) begin
        intr_d[c] = 1'b1;
      end
      case (state_q[c])
        ESC_IDLE: begin
          // escalate on the same edge that the count crosses
          if ((inc[c] != '0) && (accu_d[c] >= accum_thresh_i)) begin
            state_d[c] = ESC_PHASE0;
            timer_d[c] = '0;
          end
        end
        ESC_PHASE0, ESC_PHASE1: begin
          if (timer_q[c] == esc_cycles_i) begin
            state_d[c] = (state_q[c] == ESC_PHASE0) ? ESC_PHASE1 : ESC_TERMINAL;
            timer_d[c] = '0;
          end else begin
            timer_d[c] = timer_q[c] + 1'b1;
          end
        end
        default: begin
          // terminal holds until clear
          state_d[c] = ESC_TERMINAL;
        end
      endcase
      if (clr_i[c]) begin
        accu_d[c]  = '0;
        intr_d[c]  = 1'b0;
        state_d[c] = ESC_IDLE;
        timer_d[c] = '0;
      end
    end
  end

  always_comb begin
    leave_idle = 1'b0;
    for (int c = 0; c < NumClasses; c++) begin
      if ((state_q[c] == ESC_IDLE) && (state_d[c] != ESC_IDLE)) begin
        leave_idle = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      accu_q   <= '0;
      intr_q   <= '0;
      state_q  <= {NumClasses{ESC_IDLE}};
      timer_q  <= '0;
      crash_q  <= '0;
      dumped_q <= 1'b0;
    end else begin
      accu_q  <= accu_d;
      intr_q  <= intr_d;
      state_q <= state_d;
      timer_q <= timer_d;
      // snapshot of the first escalation since reset
      if (leave_idle && !dumped_q) begin
        dumped_q <= 1'b1;
        for (int c = 0; c < NumClasses; c++) begin
          crash_q[c] <= {state_d[c], accu_d[c]};
        end
      end
    end
  end

  // esc 0 from phase 0 on, esc 1 from phase 1 on, OR over classes
  always_comb begin
    esc_req_o = '0;
    for (int c = 0; c < NumClasses; c++) begin
      if (state_q[c] != ESC_IDLE) begin
        esc_req_o[0] = 1'b1;
      end
      if ((state_q[c] == ESC_PHASE1) || (state_q[c] == ESC_TERMINAL)) begin
        esc_req_o[1] = 1'b1;
      end
    end
  end

  assign intr_o      = intr_q;
  assign crashdump_o = crash_q;

  for (genvar c = 0; c < NumClasses; c++) begin : gen_chk
    a_phase_order: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (state_q[c] != $past(state_q[c])) |->
        $past(clr_i[c]) ||
        ((state_q[c] == ESC_PHASE0) && ($past(state_q[c]) == ESC_IDLE)) ||
        ((state_q[c] == ESC_PHASE1) && ($past(state_q[c]) == ESC_PHASE0)) ||
        ((state_q[c] == ESC_TERMINAL) && ($past(state_q[c]) == ESC_PHASE1)));

    a_enter_thresh: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      ((state_q[c] == ESC_PHASE0) && ($past(state_q[c]) == ESC_IDLE)) |->
        (accu_q[c] >= accum_thresh_i));
  end

endmodule

// File: design/alert_receiver.sv
// alert receiver with four-phase ack handshake, no ping support
// the source pair is sampled once before use and not synchronized further
`timescale 1ns/1ns

module alert_receiver
  import alert_prot_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  alert_tx_t alert_tx_i,
  output alert_rx_t alert_rx_o,
  output logic      alert_o,
  output logic      integ_fail_o
);

  typedef enum logic {
    RX_IDLE = 1'b0,
    RX_ACK  = 1'b1
  } rx_state_e;

  rx_state_e state_q, state_d;
  alert_tx_t alert_q;
  logic      pair_active;
  logic      pair_idle;
  logic      pair_bad;
  logic      bad_q;
  logic      ack_p_q;
  logic      ack_n_q;
  logic      alert_stb_q;
  logic      integ_q;

  assign pair_active = alert_q.alert_p & ~alert_q.alert_n;
  assign pair_idle   = ~alert_q.alert_p & alert_q.alert_n;
  assign pair_bad    = alert_q.alert_p == alert_q.alert_n;

  // held alert stays in RX_ACK, so one strobe per handshake
  always_comb begin
    state_d = state_q;
    case (state_q)
      RX_IDLE: begin
        if (pair_active) begin
          state_d = RX_ACK;
        end
      end
      RX_ACK: begin
        if (pair_idle) begin
          state_d = RX_IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      alert_q     <= '{alert_p: 1'b0, alert_n: 1'b1};
      state_q     <= RX_IDLE;
      ack_p_q     <= 1'b0;
      ack_n_q     <= 1'b1;
      alert_stb_q <= 1'b0;
      bad_q       <= 1'b0;
      integ_q     <= 1'b0;
    end else begin
      alert_q     <= alert_tx_i;
      state_q     <= state_d;
      ack_p_q     <= (state_d == RX_ACK);
      ack_n_q     <= (state_d != RX_ACK);
      alert_stb_q <= (state_q == RX_IDLE) && (state_d == RX_ACK);
      bad_q       <= pair_bad;
      // first cycle of an invalid pair only
      integ_q     <= pair_bad & ~bad_q;
    end
  end

  assign alert_rx_o   = '{ack_p: ack_p_q, ack_n: ack_n_q};
  assign alert_o      = alert_stb_q;
  assign integ_fail_o = integ_q;

  a_ack_compl: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    alert_rx_o.ack_p != alert_rx_o.ack_n);

endmodule

// File: design/alert_evt_if.sv
// decoded alert events from the receivers to the class controller
// strobes are single-cycle pulses; class map and enables are static config
`timescale 1ns/1ns

interface alert_evt_if
  import alert_cfg_pkg::*;
();

  logic   [NumAlerts-1:0] alert_stb;
  logic   [NumAlerts-1:0] integ_stb;
  class_e [NumAlerts-1:0] alert_cls;
  logic   [NumAlerts-1:0] alert_en;

  modport recv (
    output alert_stb,
    output integ_stb
  );

  modport ctrl (
    input alert_stb,
    input integ_stb,
    input alert_cls,
    input alert_en
  );

endinterface

// File: design/alert_cfg_pkg.sv
// sizes and state encodings of the alert handler
// fixed at 4 alerts, 2 classes and 2 escalation outputs
package alert_cfg_pkg;

  localparam int NumAlerts  = 4;
  localparam int NumClasses = 2;
  localparam int NumEsc     = 2;

  // saturating per-class alert counter
  localparam int AccuW   = 8;
  // escalation phase timer
  localparam int CyclesW = 8;

  // per class: 2 state bits above AccuW count bits, class A in the low half
  localparam int CrashW = NumClasses * (2 + AccuW);

  typedef enum logic {
    CLASS_A = 1'b0,
    CLASS_B = 1'b1
  } class_e;

  typedef enum logic [1:0] {
    ESC_IDLE     = 2'd0,
    ESC_PHASE0   = 2'd1,
    ESC_PHASE1   = 2'd2,
    ESC_TERMINAL = 2'd3
  } esc_state_e;

endpackage

// File: design/alert_prot_pkg.sv
// differential wire pairs of the off-chip alert and escalation protocols
// idle levels: alert_p=0/alert_n=1, ack_p=0/ack_n=1, esc_p=0/esc_n=1, resp_p=0/resp_n=1
package alert_prot_pkg;

  // source to receiver
  typedef struct packed {
    logic alert_p;
    logic alert_n;
  } alert_tx_t;

  // receiver back to source, no ping wires
  typedef struct packed {
    logic ack_p;
    logic ack_n;
  } alert_rx_t;

  // sender to escalation device
  typedef struct packed {
    logic esc_p;
    logic esc_n;
  } esc_tx_t;

  // device response, toggling complements while escalated
  typedef struct packed {
    logic resp_p;
    logic resp_n;
  } esc_rx_t;

endpackage
